/* source/sched_pkg.sv */
package sched_pkg;

	localparam int num_cores   = 4;
	localparam int load_time   = 4;                  // Instruction words per frame
	localparam int r0_width    = 8;
	localparam int frame_width = 64;
	localparam int insn_width  = 16;

	// Bits taken by the control view before padding
	localparam int ctrl_used = 4 + 2 + 2 * num_cores + 1 + 4 + num_cores * r0_width;

	typedef enum logic [1:0] {
		fence_no  = 2'd0,
		fence_acq = 2'd1,                            // Next frame waits for all cores
		fence_rel = 2'd2                             // This frame waits for all cores
	} fence_e;

	typedef struct packed {
		logic [3:0]                         insn_frame_num;
		fence_e                             fence;
		logic [num_cores-1:0]               active_vect;
		logic [num_cores-1:0]               init_vect;
		logic                               stop;
		logic [3:0]                         stop_addr;
		logic [num_cores-1:0][r0_width-1:0] init_r0;
		logic [frame_width-ctrl_used-1:0]   padding;
	} ctrl_frame_t;

	typedef struct packed {
		logic [load_time-1:0][insn_width-1:0] word;  // Indexed by load count
	} insn_frame_t;

	typedef union packed {
		ctrl_frame_t ctrl;
		insn_frame_t insn;
	} tm_frame_u;

	typedef struct packed {
		logic [num_cores-1:0]               start;
		logic [1:0]                         load_cnt;
		logic [insn_width-1:0]              insn;
		logic                               init_strobe;
		logic [num_cores-1:0]               init_vect;
		logic [num_cores-1:0][r0_width-1:0] init_r0;
	} core_bus_t;

	typedef struct packed {
		logic [3:0]           task_ptr;
		logic [num_cores-1:0] start;
	} sched_mon_t;

endpackage

/* source/core_pkg.sv */
package core_pkg;

	// Core side of the instruction word, same width as a bus word
	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_add = 2'd1,
		op_sub = 2'd2,
		op_xor = 2'd3
	} opcode_e;

	typedef struct packed {
		opcode_e    op;
		logic [3:0] busy;                            // Extra cycles after the first
		logic [9:0] imm;                             // Low bits feed r0
	} insn_t;

endpackage

/* source/task_memory.sv */
`timescale 1ns/10ps

module task_memory #(
	parameter int tm_depth = 16
) (
	input  logic                        clk,
	input  logic                        tm_wr,
	input  logic [$clog2(tm_depth)-1:0] tm_addr,
	input  sched_pkg::tm_frame_u        tm_wdata,
	input  logic [$clog2(tm_depth)-1:0] rd_addr,
	output sched_pkg::tm_frame_u        rd_frame
);
	import sched_pkg::*;

	tm_frame_u frames [tm_depth];                    // Loaded by the environment under reset

	always_ff @(posedge clk) begin
		if (tm_wr) begin
			frames[tm_addr] <= tm_wdata;
		end
	end

	// Pointer lookup lands in the same cycle
	assign rd_frame = frames[rd_addr];

endmodule

/* source/task_scheduler.sv */
`timescale 1ns/10ps

module task_scheduler #(
	parameter int tm_depth = 16
) (
	input  logic                            clk,
	input  logic                            reset,
	output logic [$clog2(tm_depth)-1:0]     rd_addr,
	input  sched_pkg::tm_frame_u            rd_frame,
	input  logic [sched_pkg::num_cores-1:0] ready,
	output sched_pkg::core_bus_t            core_bus,
	output logic                            halted,
	output sched_pkg::sched_mon_t           mon
);
	import sched_pkg::*;

	localparam int aw = $clog2(tm_depth);
	localparam logic [1:0] last_cnt = 2'(load_time - 1);

	logic [aw-1:0]                      task_ptr;
	logic [3:0]                         frame_cnt;     // Instruction frames left
	fence_e                             fence;
	logic [num_cores-1:0]               active_vect;
	logic                               stop_r;
	logic [3:0]                         stop_addr_r;
	logic                               streaming;     // Load window open
	logic [1:0]                         load_cnt;
	logic                               init_strobe;
	logic [num_cores-1:0]               init_vect;
	logic [num_cores-1:0][r0_width-1:0] init_r0;

	ctrl_frame_t ctrl;
	insn_frame_t insn_view;
	logic        in_ctrl;
	logic        all_ready;
	logic        next_ready;
	logic        cur_ready;
	logic        is_halt;
	logic        accept;
	logic        frame_go;
	logic        load_last;
	logic        last_frame;

	assign rd_addr = task_ptr;

	// One memory word, read as control or as instructions by the frame count
	assign in_ctrl   = frame_cnt == 4'd0;
	assign ctrl      = in_ctrl ? rd_frame.ctrl : '0;
	assign insn_view = in_ctrl ? '0 : rd_frame.insn;

	assign all_ready  = &ready;
	assign next_ready = (ctrl.active_vect & ~ready) == '0;
	assign cur_ready  = (active_vect & ~ready) == '0;
	assign is_halt    = ctrl.insn_frame_num == 4'd0 && !ctrl.stop;

	// Release frames always enter on an idle array
	assign accept = in_ctrl && !is_halt &&
		((next_ready && fence == fence_no && ctrl.fence != fence_rel) ||
		(all_ready && (fence == fence_acq || ctrl.fence == fence_rel)));

	assign frame_go   = !in_ctrl && !streaming && cur_ready;
	assign load_last  = streaming && load_cnt == last_cnt;
	assign last_frame = frame_cnt == 4'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			task_ptr    <= '0;
			frame_cnt   <= '0;
			fence       <= fence_no;
			active_vect <= '0;
			stop_r      <= 1'b0;
			streaming   <= 1'b0;
			load_cnt    <= '0;
			init_strobe <= 1'b0;
			halted      <= 1'b0;
		end else begin
			init_strobe <= accept;                   // Single pulse per control frame
			halted      <= in_ctrl && is_halt && all_ready;

			if (accept) begin
				frame_cnt   <= ctrl.insn_frame_num;
				active_vect <= ctrl.active_vect;
				stop_r      <= ctrl.stop;
				// Selected cores are idle here, so the first window opens at once
				streaming   <= ctrl.insn_frame_num != 4'd0;
				if (ctrl.insn_frame_num == 4'd0) begin
					task_ptr <= aw'(ctrl.stop_addr);    // Bare jump
					fence    <= fence_acq;
				end else begin
					task_ptr <= task_ptr + 1'b1;
					// Release is spent on entry
					fence    <= (ctrl.fence == fence_acq) ? fence_acq : fence_no;
				end
			end else if (frame_go) begin
				streaming <= 1'b1;
			end else if (streaming) begin
				load_cnt <= load_last ? 2'd0 : load_cnt + 2'd1;
				if (load_last) begin
					streaming <= 1'b0;
					frame_cnt <= frame_cnt - 4'd1;
					if (last_frame && stop_r) begin
						task_ptr <= aw'(stop_addr_r);   // Jump after the last frame
						fence    <= fence_acq;
					end else begin
						task_ptr <= task_ptr + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			stop_addr_r <= ctrl.stop_addr;
			init_vect   <= ctrl.init_vect;
			init_r0     <= ctrl.init_r0;
		end
	end

	always_comb begin
		core_bus.start       = streaming ? active_vect : '0;
		core_bus.load_cnt    = load_cnt;
		core_bus.insn        = insn_view.word[load_cnt];
		core_bus.init_strobe = init_strobe;
		core_bus.init_vect   = init_vect;
		core_bus.init_r0     = init_r0;
	end

	always_comb begin
		mon.task_ptr = 4'(task_ptr);
		mon.start    = core_bus.start;
	end

endmodule

/* source/core_unit.sv */
`timescale 1ns/10ps

module core_unit #(
	parameter int core_id = 0
) (
	input  logic                         clk,
	input  logic                         reset,
	input  sched_pkg::core_bus_t         core_bus,
	output logic                         ready,
	output logic [sched_pkg::r0_width-1:0] r0
);
	import sched_pkg::*;
	import core_pkg::*;

	localparam logic [1:0] last_idx = 2'(load_time - 1);

	insn_t               prog [load_time];           // Captured frame
	insn_t               cur;
	logic                sel;
	logic                busy;
	logic [1:0]          pc;
	logic [3:0]          wait_cnt;
	logic                step;
	logic [r0_width-1:0] imm;
	logic [r0_width-1:0] alu;

	assign sel   = core_bus.start[core_id];
	assign cur   = prog[pc];
	assign step  = busy && wait_cnt == cur.busy;     // Last cycle of this word
	assign imm   = cur.imm[r0_width-1:0];
	assign ready = !busy;

	always_comb begin
		case (cur.op)
			op_add:  alu = r0 + imm;
			op_sub:  alu = r0 - imm;
			op_xor:  alu = r0 ^ imm;
			default: alu = r0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (sel) begin
			prog[core_bus.load_cnt] <= insn_t'(core_bus.insn);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			pc       <= '0;
			wait_cnt <= '0;
			r0       <= '0;
		end else begin
			if (core_bus.init_strobe && core_bus.init_vect[core_id]) begin
				r0 <= core_bus.init_r0[core_id];
			end else if (step) begin
				r0 <= alu;
			end

			if (sel && core_bus.load_cnt == last_idx) begin
				busy     <= 1'b1;                    // Run starts after the last word
				pc       <= '0;
				wait_cnt <= '0;
			end else if (step) begin
				wait_cnt <= '0;
				pc       <= pc + 2'd1;
				if (pc == last_idx) begin
					busy <= 1'b0;
				end
			end else if (busy) begin
				wait_cnt <= wait_cnt + 4'd1;
			end
		end
	end

endmodule

/* source/sched_top.sv */
`timescale 1ns/10ps

module sched_top #(
	parameter int tm_depth = 16
) (
	input  logic                                                      clk,
	input  logic                                                      reset,
	input  logic                                                      tm_wr,
	input  logic [$clog2(tm_depth)-1:0]                               tm_addr,
	input  sched_pkg::tm_frame_u                                      tm_wdata,
	output logic                                                      halted,
	output logic [sched_pkg::num_cores-1:0]                           core_busy,
	output logic [sched_pkg::num_cores-1:0][sched_pkg::r0_width-1:0]  core_r0,
	output sched_pkg::sched_mon_t                                     mon
);
	import sched_pkg::*;

	localparam int aw = $clog2(tm_depth);

	logic [aw-1:0]        rd_addr;
	tm_frame_u            rd_frame;
	core_bus_t            core_bus;
	logic [num_cores-1:0] ready;

	assign core_busy = ~ready;

	task_memory #(
		.tm_depth(tm_depth)
	) u_memory (
		.clk      (clk),
		.tm_wr    (tm_wr),
		.tm_addr  (tm_addr),
		.tm_wdata (tm_wdata),
		.rd_addr  (rd_addr),
		.rd_frame (rd_frame)
	);

	task_scheduler #(
		.tm_depth(tm_depth)
	) u_scheduler (
		.clk      (clk),
		.reset    (reset),
		.rd_addr  (rd_addr),
		.rd_frame (rd_frame),
		.ready    (ready),
		.core_bus (core_bus),
		.halted   (halted),
		.mon      (mon)
	);

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		core_unit #(
			.core_id(i)
		) u_core (
			.clk      (clk),
			.reset    (reset),
			.core_bus (core_bus),
			.ready    (ready[i]),
			.r0       (core_r0[i])
		);
	end

endmodule

/* testbench/sched_chk.sv */
`timescale 1ns/10ps

module sched_chk (
	input logic                 clk,
	input logic                 reset,
	input sched_pkg::core_bus_t core_bus,
	input logic                 accept,
	input sched_pkg::tm_frame_u rd_frame,
	input logic                 halted
);
	import sched_pkg::*;

	int                   fail_count = 0;            // Assertion failures so far
	logic [num_cores-1:0] frame_active;              // Taken from the accepted control word

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_active <= '0;
		end else if (accept) begin
			frame_active <= rd_frame.ctrl.active_vect;
		end
	end

	start_in_active: assert property (@(posedge clk) disable iff (reset)
		(core_bus.start & ~frame_active) == '0)
		else begin
			$error("start selects a core outside the accepted active vector");
			fail_count++;
		end

	// A load window always opens at word 0
	window_opens_at_zero: assert property (@(posedge clk) disable iff (reset)
		$rose(|core_bus.start) |-> core_bus.load_cnt == 2'd0)
		else begin
			$error("load window opened with a nonzero load_cnt");
			fail_count++;
		end

	window_counts_up: assert property (@(posedge clk) disable iff (reset)
		(|core_bus.start && core_bus.load_cnt != 2'd3) |=>
		(|core_bus.start && core_bus.load_cnt == $past(core_bus.load_cnt) + 2'd1))
		else begin
			$error("load_cnt wrapped or stopped inside a load window");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (core_bus.start == '0 && !core_bus.init_strobe))
		else begin
			$error("start or init_strobe high in the cycle after reset");
			fail_count++;
		end

	quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
		halted |-> core_bus.start == '0)
		else begin
			$error("start high while halted");
			fail_count++;
		end

endmodule

bind task_scheduler sched_chk u_chk (
	.clk      (clk),
	.reset    (reset),
	.core_bus (core_bus),
	.accept   (accept),
	.rd_frame (rd_frame),
	.halted   (halted)
);

/* testbench/sched_tb.sv */
`timescale 1ns/10ps

module sched_tb;
	import sched_pkg::*;
	import core_pkg::*;

	localparam int tm_depth        = 16;
	localparam int addr_w          = $clog2(tm_depth);
	localparam int num_rows        = 4;
	localparam int max_frames      = 10;             // All written inside the reset window
	localparam int watchdog_cycles = num_rows * max_frames * load_time * 20;

	typedef struct packed {
		logic [3:0]                         len;
		logic                               rel_valid;
		logic [3:0]                         rel_addr;  // Release-fenced control frame
		logic [num_cores-1:0][r0_width-1:0] exp_r0;
		tm_frame_u [max_frames-1:0]         frames;
	} prog_row_t;

	logic                               clk = 1'b0;
	logic                               reset;
	logic                               tm_wr;
	logic [addr_w-1:0]                  tm_addr;
	tm_frame_u                          tm_wdata;
	logic                               halted;
	logic [num_cores-1:0]               core_busy;
	logic [num_cores-1:0][r0_width-1:0] core_r0;
	sched_mon_t                         mon;

	prog_row_t programs [num_rows];
	integer    seed;

	sched_top #(
		.tm_depth(tm_depth)
	) dut0 (
		.clk       (clk),
		.reset     (reset),
		.tm_wr     (tm_wr),
		.tm_addr   (tm_addr),
		.tm_wdata  (tm_wdata),
		.halted    (halted),
		.core_busy (core_busy),
		.core_r0   (core_r0),
		.mon       (mon)
	);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		stop_run();
	endtask

	function automatic logic [15:0] encode_insn(input opcode_e op, input logic [3:0] busy,
		input logic [9:0] imm);
		insn_t w;
		w.op   = op;
		w.busy = busy;
		w.imm  = imm;
		return w;
	endfunction

	function automatic tm_frame_u ctrl_frame(input logic [3:0] num, input fence_e fence,
		input logic [3:0] active, input logic [3:0] init, input logic stop,
		input logic [3:0] stop_addr, input logic [31:0] init_r0);
		tm_frame_u f;
		f                     = '0;
		f.ctrl.insn_frame_num = num;
		f.ctrl.fence          = fence;
		f.ctrl.active_vect    = active;
		f.ctrl.init_vect      = init;
		f.ctrl.stop           = stop;
		f.ctrl.stop_addr      = stop_addr;
		f.ctrl.init_r0        = init_r0;         // Core 3 in the top byte
		return f;
	endfunction

	function automatic tm_frame_u insn_frame(input logic [15:0] w0, input logic [15:0] w1,
		input logic [15:0] w2, input logic [15:0] w3);
		tm_frame_u f;
		f.insn.word[0] = w0;                     // Runs first
		f.insn.word[1] = w1;
		f.insn.word[2] = w2;
		f.insn.word[3] = w3;
		return f;
	endfunction

	function automatic logic [7:0] apply_insn(input logic [7:0] r, input logic [15:0] word);
		insn_t      w;
		logic [7:0] imm;
		w   = word;
		imm = w.imm[7:0];
		case (w.op)
			op_add:  return r + imm;
			op_sub:  return r - imm;
			op_xor:  return r ^ imm;
			default: return r;
		endcase
	endfunction

	// Frame walk in program order, timing left out
	function automatic logic [num_cores-1:0][r0_width-1:0] run_model(input prog_row_t row);
		logic [num_cores-1:0][r0_width-1:0] r;
		ctrl_frame_t c;
		logic [3:0]  ptr;
		logic [3:0]  left;
		logic [3:0]  active;
		logic        stop;
		logic [3:0]  stop_addr;
		r         = '0;
		ptr       = '0;
		left      = '0;
		active    = '0;
		stop      = 1'b0;
		stop_addr = '0;
		for (int step = 0; step < 64; step++) begin
			if (left == 4'd0) begin
				c = row.frames[ptr].ctrl;
				if (c.insn_frame_num == 4'd0 && !c.stop) begin
					break;                       // Halt
				end
				for (int i = 0; i < num_cores; i++) begin
					if (c.init_vect[i]) begin
						r[i] = c.init_r0[i];
					end
				end
				active    = c.active_vect;
				left      = c.insn_frame_num;
				stop      = c.stop;
				stop_addr = c.stop_addr;
				ptr       = (left == 4'd0) ? c.stop_addr : ptr + 4'd1;
			end else begin
				for (int i = 0; i < num_cores; i++) begin
					for (int k = 0; k < load_time; k++) begin
						if (active[i]) begin
							r[i] = apply_insn(r[i], row.frames[ptr].insn.word[k]);
						end
					end
				end
				left = left - 4'd1;
				ptr  = (left == 4'd0 && stop) ? stop_addr : ptr + 4'd1;
			end
		end
		return r;
	endfunction

	task automatic build_table();
		prog_row_t row;
		// One frame on every core
		row           = '0;
		row.len       = 4'd3;
		row.frames[0] = ctrl_frame(4'd1, fence_no, 4'hF, 4'hF, 1'b0, 4'd0, 32'h40302010);
		row.frames[1] = insn_frame(encode_insn(op_add, 4'd0, 10'h005),
			encode_insn(op_xor, 4'd2, 10'h30F), encode_insn(op_sub, 4'd1, 10'h003),
			encode_insn(op_nop, 4'd0, 10'h3FF));
		row.exp_r0    = 32'h47372717;
		programs[0]   = row;
		// Partial init, overlapping runs, release fence at frame 4
		row           = '0;
		row.len       = 4'd7;
		row.rel_valid = 1'b1;
		row.rel_addr  = 4'd4;
		row.frames[0] = ctrl_frame(4'd1, fence_no, 4'b1010, 4'hF, 1'b0, 4'd0, 32'h44332211);
		row.frames[1] = insn_frame(encode_insn(op_add, 4'd15, 10'h010),
			encode_insn(op_add, 4'd15, 10'h001), encode_insn(op_nop, 4'd15, 10'h000),
			encode_insn(op_nop, 4'd15, 10'h000));
		row.frames[2] = ctrl_frame(4'd1, fence_no, 4'b0101, 4'h0, 1'b0, 4'd0, 32'hFFFFFFFF);
		row.frames[3] = insn_frame(encode_insn(op_xor, 4'd0, 10'h00F),
			encode_insn(op_nop, 4'd0, 10'h000), encode_insn(op_nop, 4'd0, 10'h000),
			encode_insn(op_add, 4'd0, 10'h001));
		row.frames[4] = ctrl_frame(4'd1, fence_rel, 4'b0101, 4'b0001, 1'b0, 4'd0, 32'hAABBCC70);
		row.frames[5] = insn_frame(encode_insn(op_sub, 4'd1, 10'h010),
			encode_insn(op_nop, 4'd0, 10'h000), encode_insn(op_nop, 4'd0, 10'h000),
			encode_insn(op_nop, 4'd0, 10'h000));
		row.exp_r0    = 32'h552D3360;
		programs[1]   = row;
		// Jump over frames 2 to 4, then a bare jump over frame 8
		row           = '0;
		row.len       = 4'd10;
		row.frames[0] = ctrl_frame(4'd1, fence_no, 4'hF, 4'b0011, 1'b1, 4'd5, 32'h00000804);
		row.frames[1] = insn_frame(encode_insn(op_add, 4'd2, 10'h001),
			encode_insn(op_add, 4'd0, 10'h002), encode_insn(op_nop, 4'd0, 10'h000),
			encode_insn(op_nop, 4'd0, 10'h000));
		row.frames[2] = ctrl_frame(4'd1, fence_no, 4'hF, 4'hF, 1'b0, 4'd0, 32'hDEDEDEDE);
		row.frames[3] = insn_frame(encode_insn(op_xor, 4'd0, 10'h0FF),
			encode_insn(op_add, 4'd0, 10'h011), encode_insn(op_nop, 4'd0, 10'h000),
			encode_insn(op_nop, 4'd0, 10'h000));
		row.frames[4] = ctrl_frame(4'd1, fence_no, 4'hF, 4'hF, 1'b0, 4'd0, 32'h5A5A5A5A);
		row.frames[5] = ctrl_frame(4'd1, fence_no, 4'b1100, 4'h0, 1'b0, 4'd0, 32'h00000000);
		row.frames[6] = insn_frame(encode_insn(op_sub, 4'd0, 10'h001),
			encode_insn(op_nop, 4'd0, 10'h000), encode_insn(op_nop, 4'd0, 10'h000),
			encode_insn(op_nop, 4'd0, 10'h000));
		row.frames[7] = ctrl_frame(4'd0, fence_no, 4'h0, 4'h0, 1'b1, 4'd9, 32'h00000000);
		row.frames[8] = ctrl_frame(4'd1, fence_no, 4'hF, 4'hF, 1'b0, 4'd0, 32'h5A5A5A5A);
		row.exp_r0    = 32'h02020B07;
		programs[2]   = row;
	endtask

	task automatic random_insn_frame(output tm_frame_u f);
		logic [15:0] w [load_time];
		for (int k = 0; k < load_time; k++) begin
			w[k] = encode_insn(opcode_e'(2'($random(seed))), 4'($random(seed)),
				10'($random(seed)));
		end
		f = insn_frame(w[0], w[1], w[2], w[3]);
	endtask

	task automatic build_random_row();
		prog_row_t   row;
		logic [3:0]  act0;
		logic [3:0]  act1;
		logic [3:0]  init0;
		logic [3:0]  init1;
		logic [31:0] r0_0;
		logic [31:0] r0_1;
		fence_e      fen0;
		fence_e      fen1;
		row   = '0;
		act0  = 4'($random(seed));
		act1  = 4'($random(seed));
		init0 = 4'($random(seed));
		init1 = 4'($random(seed)) & act1;        // Only idle cores take a new r0
		r0_0  = $random(seed);
		r0_1  = $random(seed);
		fen0  = fence_e'(2'($unsigned($random(seed)) % 3));
		fen1  = fence_e'(2'($unsigned($random(seed)) % 3));
		if (act0 == 4'h0) begin
			act0 = 4'h1;
		end
		if (act1 == 4'h0) begin
			act1 = 4'h8;
		end
		row.len       = 4'd6;
		row.rel_valid = (fen1 == fence_rel);
		row.rel_addr  = 4'd3;
		row.frames[0] = ctrl_frame(4'd2, fen0, act0, init0, 1'b0, 4'd0, r0_0);
		random_insn_frame(row.frames[1]);
		random_insn_frame(row.frames[2]);
		row.frames[3] = ctrl_frame(4'd1, fen1, act1, init1, 1'b0, 4'd0, r0_1);
		random_insn_frame(row.frames[4]);
		row.exp_r0    = run_model(row);
		programs[3]   = row;
	endtask

	task automatic run_row(input int n);
		prog_row_t            row;
		logic [3:0]           prev_ptr;
		logic [num_cores-1:0] prev_start;
		logic [num_cores-1:0] prev_busy;
		logic                 rel_seen;
		row = programs[n];
		// Memory is written while reset is high
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			reset    = 1'b1;
			tm_wr    = (i < int'(row.len));
			tm_addr  = addr_w'(i);
			tm_wdata = row.frames[i];
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		tm_wr = 1'b0;
		@(negedge clk);
		assert (!halted && mon.start == '0)
			else report_error($sformatf("row %0d: halted %b start %b right after reset",
				n, halted, mon.start));
		prev_ptr   = mon.task_ptr;
		prev_start = mon.start;
		prev_busy  = core_busy;
		rel_seen   = 1'b0;
		while (!halted) begin
			@(negedge clk);
			if (row.rel_valid && prev_ptr == row.rel_addr && prev_start == '0 &&
				mon.start != '0) begin
				rel_seen = 1'b1;
				assert (prev_busy == '0)
					else report_error($sformatf("row %0d: release frame entered with busy %b",
						n, prev_busy));
			end
			prev_ptr   = mon.task_ptr;
			prev_start = mon.start;
			prev_busy  = core_busy;
		end
		assert (!row.rel_valid || rel_seen)
			else report_error($sformatf("row %0d: release frame never started", n));
		assert (core_busy == '0)
			else report_error($sformatf("row %0d: busy %b while halted", n, core_busy));
		for (int c = 0; c < num_cores; c++) begin
			assert (core_r0[c] == row.exp_r0[c])
				else report_error($sformatf("row %0d core %0d: r0 %h, expected %h",
					n, c, core_r0[c], row.exp_r0[c]));
		end
	endtask

	initial begin
		reset    = 1'b1;
		tm_wr    = 1'b0;
		tm_addr  = '0;
		tm_wdata = '0;
		seed     = 56374;
		build_table();
		build_random_row();
		for (int n = 0; n < num_rows; n++) begin
			run_row(n);
		end
		if (dut0.u_scheduler.u_chk.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			stop_run();
		end
	end

	// Bound scheduler checker
	initial begin
		wait (dut0.u_scheduler.u_chk.fail_count != 0);
		$display("A scheduler checker assertion failed at %0t", $time);
		stop_run();
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: programs did not all reach halt within %0d cycles", watchdog_cycles);
		stop_run();
	end

endmodule

/* task_sched.f */
source/sched_pkg.sv
source/core_pkg.sv
source/task_memory.sv
source/task_scheduler.sv
source/core_unit.sv
source/sched_top.sv
testbench/sched_chk.sv
testbench/sched_tb.sv
